//--- design/booth_cfg.svh
/*
 * Operand width and Booth row count for the 11x11 unsigned multiplier.
 * The six-row encoding and the Dadda stage heights assume these exact values.
 */
`ifndef BOOTH_CFG_SVH
`define BOOTH_CFG_SVH

// Unsigned operand width
`define BOOTH_NUMBIT 11
// Radix-4 rows for an 11-bit operand with a zero top extension
`define BOOTH_NUM_PP 6

`endif

//--- design/booth_pkg.sv
/*
 * Vector types shared by the multiplier RTL and its testbench.
 * Widths follow the macros in booth_cfg.svh.
 */
`default_nettype none

`include "booth_cfg.svh"

package booth_pkg;

	// One unsigned operand
	typedef logic [`BOOTH_NUMBIT-1:0] operand_t;
	// Booth row, one bit wider to hold 2A
	typedef logic [`BOOTH_NUMBIT:0] pp_t;
	// Negation flag per row
	typedef logic [`BOOTH_NUM_PP-1:0] signs_t;
	// Full product, also the width of the reduced sum and carry rows
	typedef logic [2*`BOOTH_NUMBIT-1:0] product_t;

endpackage

`default_nettype wire

//--- design/booth_pp_if.sv
/*
 * Booth encoder to Dadda tree bundle.
 * pp_valid is a single-cycle strobe with no handshake.
 */
`timescale 1ns/1ns
`default_nettype none

`include "booth_cfg.svh"

interface booth_pp_if import booth_pkg::*; ();

	// Unshifted rows, row i carries weight 4^i
	pp_t rows [`BOOTH_NUM_PP];
	// Set where a row is the inverted form and still needs its +1
	signs_t signs;
	logic pp_valid;

	modport encoder (output rows, output signs, output pp_valid);
	modport reducer (input rows, input signs, input pp_valid);

endinterface

`default_nettype wire

//--- design/booth_operand_reg.sv
/*
 * Input-side operand register, loads only when in_valid is high.
 * A new pair may arrive every cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module booth_operand_reg import booth_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  operand_t a_in,
	input  operand_t b_in,
	output operand_t a,
	output operand_t b,
	output logic     op_valid
);

	// Strobe follows in_valid by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= in_valid;
		end
	end

	// Operands hold between strobes so the datapath stays quiet
	always_ff @(posedge clk) begin
		if (in_valid) begin
			a <= a_in;
			b <= b_in;
		end
	end

endmodule

`default_nettype wire

//--- design/booth.sv
/*
 * Modified radix-4 Booth encoder, purely combinational.
 * Multiplicand b is zero extended, so the top triplet never goes negative.
 * Negative rows come out inverted; the +1 is added in the Dadda tree.
 */
`timescale 1ns/1ns
`default_nettype none

`include "booth_cfg.svh"

module booth import booth_pkg::*; (
	input  operand_t    a,
	input  operand_t    b,
	input  logic        op_valid,
	booth_pp_if.encoder pp
);

	// b with a zero below bit 0 and a zero above the MSB
	logic [`BOOTH_NUMBIT+1:0] b_ext;

	assign b_ext = {1'b0, b, 1'b0};

	/*
	 * Triplet code to row
	 *   000 -> 0     001 -> A     010 -> A     011 -> 2A
	 *   100 -> -2A   101 -> -A    110 -> -A    111 -> -0
	 */
	function automatic pp_t booth_select(input logic [2:0] code, input operand_t mcand);
		pp_t row;
		case (code)
			3'b000: row = '0;
			3'b001,
			3'b010: row = {1'b0, mcand};
			3'b011: row = {mcand, 1'b0};
			// Negative codes give the one's complement only
			3'b100: row = ~{mcand, 1'b0};
			3'b101,
			3'b110: row = ~{1'b0, mcand};
			// Inverted zero, the sign carry brings it back to 0
			default: row = '1;
		endcase
		return row;
	endfunction

	always_comb begin
		for (int i = 0; i < `BOOTH_NUM_PP; i++) begin
			// Overlapping triplets step by two bits
			pp.rows[i] = booth_select(b_ext[2*i +: 3], a);
			// Triplet MSB marks a subtraction
			pp.signs[i] = b_ext[2*i+2];
		end
	end

	// No register here, same cycle as op_valid
	assign pp.pp_valid = op_valid;

endmodule

`default_nettype wire

//--- design/dadda_tree.sv
/*
 * Dadda reduction of the six Booth rows to a registered sum/carry pair.
 * Results are modulo 2^22; carries out of the top column are dropped.
 * Stage heights 6,4,3,2 assume a starting column height of 7.
 */
`timescale 1ns/1ns
`default_nettype none

`include "booth_cfg.svh"

module dadda_tree import booth_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	booth_pp_if.reducer pp,
	output product_t    sum_row,
	output product_t    carry_row,
	output logic        red_valid
);

	localparam int PW = 2 * `BOOTH_NUMBIT;
	localparam int RW = `BOOTH_NUMBIT + 1;
	// Tallest column: six rows plus one sign or correction bit
	localparam int MAXH = `BOOTH_NUM_PP + 1;
	localparam int NSTAGE = 4;
	localparam int HEIGHT [NSTAGE] = '{6, 4, 3, 2};

	// Minus the sum of every row's sign weight, wrapped to PW bits
	function automatic product_t corr_row();
		product_t c;
		c = '0;
		for (int i = 0; i < `BOOTH_NUM_PP; i++) begin
			c = c - (product_t'(1) << (2 * i + RW));
		end
		return c;
	endfunction

	localparam product_t CORR = corr_row();

	product_t sum_next;
	product_t carry_next;

	always_comb begin
		logic [MAXH-1:0] col [PW];
		logic [MAXH-1:0] nxt [PW];
		int cnt [PW];
		int ncnt [PW];
		int k;
		int h;
		logic x;
		logic y;
		logic z;

		for (int w = 0; w < PW; w++) begin
			col[w] = '0;
			cnt[w] = 0;
		end

		// Dot matrix, row i shifted by 2i
		for (int i = 0; i < `BOOTH_NUM_PP; i++) begin
			for (int j = 0; j < RW; j++) begin
				col[2*i+j][cnt[2*i+j]] = pp.rows[i][j];
				cnt[2*i+j]++;
			end
			// +1 that completes the negation
			col[2*i][cnt[2*i]] = pp.signs[i];
			cnt[2*i]++;
			// Inverted sign bit replaces the sign extension
			if (2 * i + RW < PW) begin
				col[2*i+RW][cnt[2*i+RW]] = ~pp.signs[i];
				cnt[2*i+RW]++;
			end
		end
		for (int w = 0; w < PW; w++) begin
			if (CORR[w]) begin
				col[w][cnt[w]] = 1'b1;
				cnt[w]++;
			end
		end

		for (int st = 0; st < NSTAGE; st++) begin
			for (int w = 0; w < PW; w++) begin
				nxt[w] = '0;
				ncnt[w] = 0;
			end
			// Low to high, so carries from w-1 count toward column w
			for (int w = 0; w < PW; w++) begin
				k = 0;
				for (int n = 0; n < MAXH / 2; n++) begin
					h = cnt[w] - k + ncnt[w];
					x = col[w][k];
					y = col[w][k+1];
					z = col[w][k+2];
					if (h > HEIGHT[st] + 1 && cnt[w] - k >= 3) begin
						// Full adder, column shrinks by two
						nxt[w][ncnt[w]] = x ^ y ^ z;
						ncnt[w]++;
						if (w + 1 < PW) begin
							nxt[w+1][ncnt[w+1]] = (x & y) | (x & z) | (y & z);
							ncnt[w+1]++;
						end
						k += 3;
					end else if (h == HEIGHT[st] + 1 && cnt[w] - k >= 2) begin
						// Half adder, column shrinks by one
						nxt[w][ncnt[w]] = x ^ y;
						ncnt[w]++;
						if (w + 1 < PW) begin
							nxt[w+1][ncnt[w+1]] = x & y;
							ncnt[w+1]++;
						end
						k += 2;
					end
				end
				// Untouched bits pass to the next stage
				for (int j = 0; j < MAXH; j++) begin
					if (j >= k && j < cnt[w]) begin
						nxt[w][ncnt[w]] = col[w][j];
						ncnt[w]++;
					end
				end
			end
			col = nxt;
			cnt = ncnt;
		end

		// Two dots left per column, empty slots are zero
		for (int w = 0; w < PW; w++) begin
			sum_next[w] = col[w][0];
			carry_next[w] = col[w][1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			red_valid <= 1'b0;
		end else begin
			red_valid <= pp.pp_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pp.pp_valid) begin
			sum_row <= sum_next;
			carry_row <= carry_next;
		end
	end

endmodule

`default_nettype wire

//--- design/booth_final_adder.sv
/*
 * Carry-propagate adder and product register.
 * The sum wraps at 22 bits, which is exact for unsigned 11x11 operands.
 */
`timescale 1ns/1ns
`default_nettype none

module booth_final_adder import booth_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  product_t sum_row,
	input  product_t carry_row,
	input  logic     red_valid,
	output product_t product,
	output logic     out_valid
);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= red_valid;
		end
	end

	// Product held until the next strobe
	always_ff @(posedge clk) begin
		if (red_valid) begin
			product <= sum_row + carry_row;
		end
	end

endmodule

`default_nettype wire

//--- design/booth_mult_top.sv
/*
 * Pipelined unsigned 11x11 Booth/Dadda multiplier, three register stages.
 * No back-pressure, so product must be taken while out_valid is high.
 */
`timescale 1ns/1ns
`default_nettype none

module booth_mult_top import booth_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  operand_t a_in,
	input  operand_t b_in,
	output logic     out_valid,
	output product_t product
);

	operand_t a;
	operand_t b;
	logic op_valid;
	product_t sum_row;
	product_t carry_row;
	logic red_valid;

	// Encoder to tree bundle
	booth_pp_if pp_bus ();

	booth_operand_reg u_operand_reg (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.a_in     (a_in),
		.b_in     (b_in),
		.a        (a),
		.b        (b),
		.op_valid (op_valid)
	);

	booth u_booth (
		.a        (a),
		.b        (b),
		.op_valid (op_valid),
		.pp       (pp_bus.encoder)
	);

	dadda_tree u_dadda_tree (
		.clk       (clk),
		.reset     (reset),
		.pp        (pp_bus.reducer),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.red_valid (red_valid)
	);

	booth_final_adder u_final_adder (
		.clk       (clk),
		.reset     (reset),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.red_valid (red_valid),
		.product   (product),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

//--- test/booth_mult_asserts.sv
/*
 * Strobe and data checks bound into booth_mult_top.
 * Expects a fixed 3-cycle latency and no back-pressure.
 */
`timescale 1ns/1ns
`default_nettype none

module booth_mult_asserts import booth_pkg::*; (
	input logic     clk,
	input logic     reset,
	input logic     in_valid,
	input logic     out_valid,
	input product_t product
);

	// Read by the testbench at the end of the run
	integer assert_failures = 0;

	// Output strobe cleared by reset and quiet right after it
	reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
		else begin
			$error("out_valid high during reset");
			assert_failures++;
		end

	after_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !out_valid [*3])
		else begin
			$error("out_valid high just after reset");
			assert_failures++;
		end

	// Each strobe comes back exactly three cycles later
	in_to_out: assert property (@(posedge clk) disable iff (reset) in_valid |-> ##3 out_valid)
		else begin
			$error("in_valid not followed by out_valid after 3 cycles");
			assert_failures++;
		end

	out_from_in: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(in_valid, 3))
		else begin
			$error("out_valid without in_valid 3 cycles before");
			assert_failures++;
		end

	product_known: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> !$isunknown(product))
		else begin
			$error("product has unknown bits while out_valid is high");
			assert_failures++;
		end

endmodule

bind booth_mult_top booth_mult_asserts u_asserts (
	.clk       (clk),
	.reset     (reset),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.product   (product)
);

`default_nettype wire

//--- test/booth_mult_tb.sv
/*
 * Trace-driven and random testbench for booth_mult_top.
 * Reads test/booth_trace.txt relative to the project root.
 * Expected products queue up on each strobe and pop on out_valid.
 */
`timescale 1ns/1ns
`default_nettype none

module booth_mult_tb import booth_pkg::*; ();

	localparam int CLK_HALF = 2;
	localparam int RESET_CYCLES = 4;
	localparam int DEPTH = 3;
	localparam int IDLE_CYCLES = 8;
	localparam int N_EXTREME = 4;
	localparam int N_RANDOM = 48;
	localparam int BURST = 8;
	localparam int GAP = 3;
	localparam int NUM_TESTS = 4;
	localparam int MARGIN = 20;
	localparam string TRACE_FILE = "test/booth_trace.txt";

	logic clk;
	logic reset;
	logic in_valid;
	operand_t a_in;
	operand_t b_in;
	logic out_valid;
	product_t product;

	integer seed;
	integer cycle = 0;
	integer timeout_limit = 0;
	integer errors = 0;
	integer sent = 0;
	integer received = 0;
	integer tests_failed = 0;

	// Vectors from the trace file
	operand_t trace_a [$];
	operand_t trace_b [$];
	product_t trace_p [$];
	// Outstanding products in arrival order
	product_t exp_q [$];
	integer start_q [$];
	string name_q [$];

	booth_mult_top dut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.a_in      (a_in),
		.b_in      (b_in),
		.out_valid (out_valid),
		.product   (product)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic check_product(input string name, input product_t expected,
		input product_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected 0x%06h, actual 0x%06h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_latency(input string name, input integer expected, input integer actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s latency: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input integer expected, input integer actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s count: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	// Lines starting with # are column notes
	task automatic load_trace();
		integer fd;
		string line;
		operand_t a;
		operand_t b;
		product_t p;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: cannot open trace file %s", TRACE_FILE);
			errors++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.getc(0) != "#" && $sscanf(line, "%h %h %h", a, b, p) == 3) begin
					trace_a.push_back(a);
					trace_b.push_back(b);
					trace_p.push_back(p);
				end
			end
			$fclose(fd);
			if (trace_a.size() == 0) begin
				$display("ERROR: trace file holds no vectors");
				errors++;
			end
		end
	endtask

	// Drives one strobe and queues its expected product and start cycle
	task automatic send(input operand_t a, input operand_t b, input product_t p,
		input string name);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		a_in = a;
		b_in = b;
		exp_q.push_back(p);
		start_q.push_back(cycle);
		name_q.push_back(name);
		sent++;
	endtask

	task automatic idle(input integer n);
		repeat (n) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	// Bounded by the watchdog below
	task automatic drain();
		idle(1);
		while (exp_q.size() > 0) begin
			@(negedge clk);
		end
	endtask

	task automatic report_test(input string name, input integer err_before);
		if (errors == err_before) begin
			$display("test %-8s ok", name);
		end else begin
			$display("test %-8s FAILED with %0d errors", name, errors - err_before);
			tests_failed++;
		end
	endtask

	// Sampled on the falling edge where outputs are stable
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			// Counts every output strobe including unexpected ones
			received++;
			if (exp_q.size() == 0) begin
				$display("ERROR: out_valid high with no product pending, cycle %0d", cycle);
				errors++;
			end else begin
				check_product(name_q[0], exp_q[0], product);
				check_latency(name_q[0], DEPTH, cycle - start_q[0]);
				exp_q.pop_front();
				start_q.pop_front();
				name_q.pop_front();
			end
		end
	end

	initial begin
		wait (timeout_limit > 0);
		while (cycle < timeout_limit) begin
			@(posedge clk);
		end
		$display("ERROR: run timed out after %0d cycles", cycle);
		$display("Test failed");
		$finish;
	end

	initial begin
		integer err_before;
		operand_t ra;
		operand_t rb;
		reset = 1'b1;
		in_valid = 1'b0;
		a_in = '0;
		b_in = '0;
		seed = 38;
		load_trace();
		// Covers every test's strobes, gaps and drains plus reset and margin
		timeout_limit = RESET_CYCLES + IDLE_CYCLES + trace_a.size() + N_EXTREME + N_RANDOM
			+ (N_RANDOM / BURST) * GAP + NUM_TESTS * (DEPTH + 2) + MARGIN;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// out_valid must stay low while no strobe is sent
		err_before = errors;
		idle(IDLE_CYCLES);
		report_test("idle", err_before);

		// Trace vectors back to back give one product per cycle
		err_before = errors;
		for (int i = 0; i < trace_a.size(); i++) begin
			send(trace_a[i], trace_b[i], trace_p[i], $sformatf("trace %0d", i));
		end
		drain();
		report_test("trace", err_before);

		err_before = errors;
		send('0, '0, 22'h000000, "zero*zero");
		send('0, '1, 22'h000000, "zero*max");
		send('1, '0, 22'h000000, "max*zero");
		send('1, '1, 22'h3FF001, "max*max");
		drain();
		report_test("extreme", err_before);

		// Bursts with idle gaps in between
		err_before = errors;
		for (int i = 0; i < N_RANDOM; i++) begin
			ra = operand_t'($random(seed));
			rb = operand_t'($random(seed));
			send(ra, rb, product_t'(ra) * product_t'(rb), $sformatf("random %0d", i));
			if ((i + 1) % BURST == 0) begin
				idle(GAP);
			end
		end
		drain();
		report_test("random", err_before);

		check_count("product", sent, received);
		errors += dut.u_asserts.assert_failures;
		$display("%0d tests, %0d failed, %0d sent, %0d received, %0d errors",
			NUM_TESTS, tests_failed, sent, received, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- booth_mult_top.f
+incdir+design
design/booth_pkg.sv
design/booth_pp_if.sv
design/booth_operand_reg.sv
design/booth.sv
design/dadda_tree.sv
design/booth_final_adder.sv
design/booth_mult_top.sv
test/booth_mult_asserts.sv
test/booth_mult_tb.sv

//--- Bender.yml
package:
  name: booth_mult

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/booth_pkg.sv
      - design/booth_pp_if.sv
      - design/booth_operand_reg.sv
      - design/booth.sv
      - design/dadda_tree.sv
      - design/booth_final_adder.sv
      - design/booth_mult_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/booth_mult_asserts.sv
      - test/booth_mult_tb.sv

//--- test/booth_trace.txt
# multiplicand a, multiplier b, expected product a*b
# all hex, a and b 11 bits, product 22 bits
000 000 000000
7FF 000 000000
000 7FF 000000
7FF 7FF 3FF001
001 001 000001
7FF 001 0007FF
001 7FF 0007FF
7FF 555 2AA2AB
7FF 2AA 154D56
555 2AA 0E3472
2AA 555 0E3472
555 555 1C6E39
2AA 2AA 0718E4
7FF 002 000FFE
7FF 003 0017FD
7FF 006 002FFA
7FF 008 003FF8
7FF 00C 005FF4
400 400 100000
400 7FF 1FFC00
7FF 400 1FFC00
123 456 04EDC2
3FF 600 17FA00
